// ==== sim.f ====
+incdir+rtl
rtl/bo_pkg.sv
rtl/bo_recent_table.sv
rtl/bo_offset_learner.sv
rtl/bo_request_gen.sv
rtl/bo_prefetcher.sv
verification/bo_prefetcher_properties.sv
verification/bo_prefetcher_tb.sv

// ==== Bender.yml ====
package:
  name: bo_prefetcher

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bo_pkg.sv
      - rtl/bo_recent_table.sv
      - rtl/bo_offset_learner.sv
      - rtl/bo_request_gen.sv
      - rtl/bo_prefetcher.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/bo_prefetcher_properties.sv
      - verification/bo_prefetcher_tb.sv

// ==== verification/bo_prefetcher_tb.sv ====
// Testbench for the best-offset prefetcher.
// Inputs are driven on the rising edge and outputs are sampled on the falling edge.
// The memory model answers every taken prefetch with a fill four cycles later,
// and it can be switched off for the no-fill region.

`timescale 1ns/1ps

`include "bo_defs.svh"

module bo_prefetcher_tb
  import bo_pkg::*;
;

  localparam int num_rows      = 6;
  localparam int fill_delay    = 4;
  localparam int ready_timeout = 200;
  localparam int offset_wait   = 400;
  localparam int miss_gap      = 16;

  // one row of the directed table
  typedef struct packed {
    blk_addr_t  addr;
    logic       ready;
    logic [7:0] hold;
    logic       exp_v;
    blk_addr_t  exp_addr;
  } stim_row_s;

  logic    clk_i      = 1'b0;
  logic    reset_i    = 1'b1;
  miss_s   miss_i     = '0;
  miss_s   fill_i     = '0;
  logic    pf_ready_i = 1'b0;
  logic    miss_ready_o;
  pf_req_s pf_req_o;
  offset_t offset_o;

  stim_row_s   rows [num_rows];
  miss_s       fill_pipe [fill_delay];
  logic        mem_en    = 1'b1;
  logic [31:0] lcg_state = 32'd80;
  int          mismatches = 0;
  int          failures   = 0;

  bo_prefetcher i_dut (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .miss_i       (miss_i),
    .miss_ready_o (miss_ready_o),
    .fill_i       (fill_i),
    .pf_req_o     (pf_req_o),
    .pf_ready_i   (pf_ready_i),
    .offset_o     (offset_o)
  );

  always #5 clk_i = ~clk_i;

  // memory model returns each taken request as a fill
  always @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < fill_delay; i++) begin
        fill_pipe[i] <= '0;
      end
      fill_i <= '0;
    end else begin
      fill_pipe[0] <= '{valid: mem_en && pf_req_o.valid && pf_ready_i, addr: pf_req_o.addr};
      for (int i = 1; i < fill_delay; i++) begin
        fill_pipe[i] <= fill_pipe[i-1];
      end
      fill_i <= fill_pipe[fill_delay-1];
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    lcg_next = state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic wait_miss_ready();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (!miss_ready_o && cycles < ready_timeout) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (miss_ready_o) else begin
      failures++;
      $display("timeout: miss_ready_o stayed low for %0d cycles", cycles);
    end
  endtask

  // miss is accepted on the second edge since the queue has room
  task automatic send_miss(input blk_addr_t addr, input logic ready);
    wait_miss_ready();
    @(posedge clk_i);
    miss_i     <= '{valid: 1'b1, addr: addr};
    pf_ready_i <= ready;
    @(posedge clk_i);
    miss_i <= '0;
  endtask

  task automatic apply_row(input stim_row_s row);
    send_miss(row.addr, row.ready);
    @(negedge clk_i);
    check_value("pf_req_o.valid", pf_req_o.valid, row.exp_v);
    if (row.exp_v) begin
      check_value("pf_req_o.addr", pf_req_o.addr, row.exp_addr);
    end
    for (int i = 0; i < row.hold; i++) begin
      @(negedge clk_i);
      // a stalled request keeps its address
      if (row.exp_v && !row.ready) begin
        check_value("pf_req_o.valid", pf_req_o.valid, 1'b1);
        check_value("pf_req_o.addr", pf_req_o.addr, row.exp_addr);
      end
    end
  endtask

  initial begin
    blk_addr_t addr_a;
    blk_addr_t addr_b;
    blk_addr_t addr;
    int        cycles;
    int        k;

    // miss, ready, hold, request expected, request address at offset 1
    rows[0] = '{26'h0001010, 1'b1, 8'd16, 1'b1, 26'h0001011};
    rows[1] = '{26'h0002020, 1'b1, 8'd16, 1'b1, 26'h0002021};
    rows[2] = '{26'h000403F, 1'b1, 8'd16, 1'b0, 26'h0000000};
    rows[3] = '{26'h0005005, 1'b0, 8'd16, 1'b1, 26'h0005006};
    rows[4] = '{26'h0007200, 1'b1, 8'd16, 1'b1, 26'h0007201};
    rows[5] = '{26'h00080FE, 1'b1, 8'd16, 1'b1, 26'h00080FF};

    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;

    // state after reset
    @(negedge clk_i);
    check_value("offset_o", offset_o, `BO_INIT_OFFSET);
    check_value("pf_req_o.valid", pf_req_o.valid, 1'b0);
    check_value("miss_ready_o", miss_ready_o, 1'b1);

    for (int r = 0; r < num_rows; r++) begin
      apply_row(rows[r]);
    end

    // two misses back to back under back-pressure
    addr_a = 26'h0006100;
    addr_b = 26'h0006200;
    wait_miss_ready();
    @(posedge clk_i);
    miss_i     <= '{valid: 1'b1, addr: addr_a};
    pf_ready_i <= 1'b0;
    @(posedge clk_i);
    miss_i <= '{valid: 1'b1, addr: addr_b};
    @(posedge clk_i);
    miss_i <= '0;
    repeat (6) begin
      @(negedge clk_i);
      check_value("pf_req_o.valid", pf_req_o.valid, 1'b1);
      check_value("pf_req_o.addr", pf_req_o.addr, addr_b + `BO_INIT_OFFSET);
    end
    @(posedge clk_i);
    pf_ready_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("pf_req_o.valid", pf_req_o.valid, 1'b0);
    repeat (miss_gap) @(negedge clk_i);

    // stride 3 stream trains the learner toward offset 3
    k = 0;
    while (k < 40 && offset_o != 3) begin
      send_miss(26'h0010000 + 3 * k, 1'b1);
      repeat (miss_gap) @(negedge clk_i);
      k++;
    end
    check_value("offset_o", offset_o, 3);

    // no fills from here on so no candidate can score
    @(posedge clk_i);
    mem_en <= 1'b0;
    repeat (fill_delay + 2) @(posedge clk_i);
    for (int n = 0; n < 24; n++) begin
      lcg_state = lcg_next(lcg_state);
      addr = {6'h20, lcg_state[27:8]};
      send_miss(addr, 1'b1);
      repeat (miss_gap) @(negedge clk_i);
    end
    cycles = 0;
    while (offset_o != `BO_INIT_OFFSET && cycles < offset_wait) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (offset_o == `BO_INIT_OFFSET) else begin
      failures++;
      $display("timeout: offset_o did not fall back after the phase without fills");
    end

    $display("summary: %0d mismatches, %0d other errors, %0d property failures",
             mismatches, failures, i_dut.i_props.fail_count);
    if (mismatches == 0 && failures == 0 && i_dut.i_props.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verification/bo_prefetcher_properties.sv ====
// Concurrent checks on the prefetcher top level, bound into bo_prefetcher.
// Replacement is seen through the accepted-miss strobe inside the top level.

`timescale 1ns/1ps

module bo_prefetcher_properties
  import bo_pkg::*;
(
  input logic    clk_i,
  input logic    reset_i,
  input miss_s   accept_i,
  input pf_req_s pf_req_o,
  input logic    pf_ready_i,
  input offset_t offset_o
);

  // count of failed assertions
  int fail_count = 0;

  // offset 0 is never a candidate
  offset_nonzero: assert property (
    @(posedge clk_i) disable iff (reset_i)
    offset_o != '0
  ) else begin
    $error("offset_o is zero");
    fail_count++;
  end

  req_idle_after_reset: assert property (
    @(posedge clk_i)
    reset_i |=> !pf_req_o.valid
  ) else begin
    $error("pf_req_o.valid high in the cycle after reset");
    fail_count++;
  end

  // a stalled request that is not replaced must not move
  req_stable_when_stalled: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (pf_req_o.valid && !pf_ready_i && !accept_i.valid)
      |=> (pf_req_o.valid && $stable(pf_req_o.addr))
  ) else begin
    $error("pending prefetch request changed while stalled");
    fail_count++;
  end

endmodule

bind bo_prefetcher bo_prefetcher_properties i_props (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .accept_i   (accept),
  .pf_req_o   (pf_req_o),
  .pf_ready_i (pf_ready_i),
  .offset_o   (offset_o)
);

// ==== rtl/bo_prefetcher.sv ====
// Best-offset prefetch engine, single bank.
// Misses are taken with miss_i.valid and miss_ready_o, requests leave with
// pf_req_o.valid and pf_ready_i. fill_i reports completed prefetch fills and
// cannot be stalled. A request appears one cycle after its miss is accepted.

`timescale 1ns/1ps

`include "bo_defs.svh"

module bo_prefetcher
  import bo_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  miss_s   miss_i,
  output logic    miss_ready_o,
  input  miss_s   fill_i,
  output pf_req_s pf_req_o,
  input  logic    pf_ready_i,
  output offset_t offset_o
);

  miss_s     accept;
  blk_addr_t lookup_addr;
  logic      lookup_v;
  logic      match;
  offset_t   offset;

  bo_offset_learner i_learner (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .miss_i        (miss_i),
    .miss_ready_o  (miss_ready_o),
    .accept_o      (accept),
    .lookup_addr_o (lookup_addr),
    .lookup_v_o    (lookup_v),
    .match_i       (match),
    .offset_o      (offset)
  );

  bo_recent_table i_table (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fill_i        (fill_i),
    .offset_i      (offset),
    .lookup_addr_i (lookup_addr),
    .lookup_v_i    (lookup_v),
    .match_o       (match)
  );

  bo_request_gen i_req_gen (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .accept_i   (accept),
    .offset_i   (offset),
    .pf_req_o   (pf_req_o),
    .pf_ready_i (pf_ready_i)
  );

  assign offset_o = offset;

endmodule

// ==== rtl/bo_request_gen.sv ====
// Prefetch request generator.
// One proposal per accepted miss: miss address plus the current offset.
// Proposals leaving the 4 KiB page are dropped. A single request register is
// kept and a newer proposal overwrites one still pending.

`timescale 1ns/1ps

`include "bo_defs.svh"

module bo_request_gen
  import bo_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,
  input  miss_s   accept_i,
  input  offset_t offset_i,
  output pf_req_s pf_req_o,
  input  logic    pf_ready_i
);

  blk_addr_u base_u;
  blk_addr_u next_u;
  logic      same_page;
  logic      load;
  logic      req_v_q;
  blk_addr_t req_addr_q;

  assign base_u.raw = accept_i.addr;
  assign next_u.raw = accept_i.addr + blk_addr_t'(offset_i);

  // also catches wrap at the top of the address space
  assign same_page = (next_u.f.page == base_u.f.page);
  assign load      = accept_i.valid && same_page;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_v_q <= 1'b0;
    end else if (load) begin
      req_v_q <= 1'b1;
    end else if (pf_ready_i) begin
      req_v_q <= 1'b0;
    end
  end

  // held under back-pressure until taken or replaced
  always_ff @(posedge clk_i) begin
    if (load) begin
      req_addr_q <= next_u.raw;
    end
  end

  assign pf_req_o.valid = req_v_q;
  assign pf_req_o.addr  = req_addr_q;

endmodule

// ==== rtl/bo_offset_learner.sv ====
// Best-offset learner with a small miss queue.
// Every queued miss is held for exactly one test per candidate offset, then popped.
// A phase ends early when one offset reaches BO_MAX_SCORE, or after BO_MAX_ROUNDS
// misses. The new offset is visible the cycle after the deciding test.

`timescale 1ns/1ps

`include "bo_defs.svh"

module bo_offset_learner
  import bo_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  miss_s     miss_i,
  output logic      miss_ready_o,
  output miss_s     accept_o,
  output blk_addr_t lookup_addr_o,
  output logic      lookup_v_o,
  input  logic      match_i,
  output offset_t   offset_o
);

  localparam int PtrW   = $clog2(`BO_MISS_DEPTH);
  localparam int CntW   = $clog2(`BO_MISS_DEPTH + 1);
  localparam int RoundW = $clog2(`BO_MAX_ROUNDS);
  localparam offset_t LastOffset = '1;

  // miss queue
  blk_addr_t       fifo_mem [`BO_MISS_DEPTH];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            push;
  logic            pop;
  logic            head_v;
  blk_addr_t       head_addr;

  // scoring state, offset 0 is never a candidate
  score_t [2**`BO_LG_OFFSETS-1:1] scores_q;
  offset_t           test_off_q;
  logic [RoundW-1:0] round_q;
  offset_t           best_off_q;
  score_t            best_score_q;
  offset_t           offset_q;

  logic    hit;
  score_t  new_score;
  logic    better;
  offset_t cand_off;
  score_t  cand_score;
  logic    last_test;
  logic    early_end;
  logic    round_end;

  assign miss_ready_o = (count_q != `BO_MISS_DEPTH);
  assign push         = miss_i.valid && miss_ready_o;
  assign head_v       = (count_q != '0);
  assign head_addr    = fifo_mem[rd_ptr_q];

  assign accept_o.valid = push;
  assign accept_o.addr  = miss_i.addr;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= miss_i.addr;
    end
  end

  // candidate base for the offset under test
  assign lookup_addr_o = head_addr - blk_addr_t'(test_off_q);
  assign lookup_v_o    = head_v;

  assign hit        = head_v && match_i;
  assign new_score  = scores_q[test_off_q] + 1'b1;
  assign better     = hit && (new_score > best_score_q);
  assign cand_off   = better ? test_off_q : best_off_q;
  assign cand_score = better ? new_score : best_score_q;

  assign last_test = head_v && (test_off_q == LastOffset);
  assign early_end = hit && (new_score == `BO_MAX_SCORE);
  assign round_end = last_test && (round_q == `BO_MAX_ROUNDS - 1);
  assign pop       = last_test;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      test_off_q   <= offset_t'(1);
      scores_q     <= '0;
      round_q      <= '0;
      best_off_q   <= '0;
      best_score_q <= '0;
      offset_q     <= offset_t'(`BO_INIT_OFFSET);
    end else begin
      // walk 1..15 against the head miss
      if (last_test || !head_v) begin
        test_off_q <= offset_t'(1);
      end else begin
        test_off_q <= test_off_q + 1'b1;
      end

      if (hit) begin
        scores_q[test_off_q] <= new_score;
        best_off_q           <= cand_off;
        best_score_q         <= cand_score;
      end

      if (early_end) begin
        // clear winner, miss keeps its remaining tests
        offset_q     <= test_off_q;
        scores_q     <= '0;
        round_q      <= '0;
        best_off_q   <= '0;
        best_score_q <= '0;
      end else if (round_end) begin
        if (cand_score > `BO_MIN_SCORE) begin
          offset_q <= cand_off;
        end else begin
          offset_q <= offset_t'(`BO_INIT_OFFSET);
        end
        scores_q     <= '0;
        round_q      <= '0;
        best_off_q   <= '0;
        best_score_q <= '0;
      end else if (last_test) begin
        round_q <= round_q + 1'b1;
      end
    end
  end

  assign offset_o = offset_q;

endmodule

// ==== rtl/bo_recent_table.sv ====
// Recent-requests table for the best-offset learner.
// Stores the base (fill address minus current offset) of each completed fill.
// Oldest entry is replaced first. Lookups see an insert from the next cycle.

`timescale 1ns/1ps

`include "bo_defs.svh"

module bo_recent_table
  import bo_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  miss_s     fill_i,
  input  offset_t   offset_i,
  input  blk_addr_t lookup_addr_i,
  input  logic      lookup_v_i,
  output logic      match_o
);

  localparam int PtrW = $clog2(`BO_HISTORY);

  blk_addr_t             tags_q [`BO_HISTORY];
  logic [`BO_HISTORY-1:0] valid_q;
  logic [PtrW-1:0]        wr_ptr_q;
  blk_addr_t             fill_base;
  logic [`BO_HISTORY-1:0] hit_vec;

  // base of the prefetch that produced this fill
  assign fill_base = fill_i.addr - blk_addr_t'(offset_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
    end else if (fill_i.valid) begin
      valid_q[wr_ptr_q] <= 1'b1;
      // fifo order, pointer wraps on its own
      wr_ptr_q <= wr_ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fill_i.valid) begin
      tags_q[wr_ptr_q] <= fill_base;
    end
  end

  always_comb begin
    for (int i = 0; i < `BO_HISTORY; i++) begin
      hit_vec[i] = valid_q[i] && (tags_q[i] == lookup_addr_i);
    end
  end

  assign match_o = lookup_v_i && (|hit_vec);

endmodule

// ==== rtl/bo_pkg.sv ====
// Types shared by the best-offset prefetcher.
// Widths come from bo_defs.svh; the page split assumes the address is wider
// than the block-in-page field.

`include "bo_defs.svh"

package bo_pkg;

  typedef logic [`BO_BLK_ADDR_W-1:0] blk_addr_t;

  typedef logic [`BO_LG_OFFSETS-1:0] offset_t;

  // wide enough to hold BO_MAX_SCORE, scores never pass it
  typedef logic [$clog2(`BO_MAX_SCORE + 1)-1:0] score_t;

  // page number above, block within page below
  typedef struct packed {
    logic [`BO_BLK_ADDR_W-`BO_PAGE_BLK_BITS-1:0] page;
    logic [`BO_PAGE_BLK_BITS-1:0]                blk;
  } blk_page_s;

  // one block address, read raw or split for the page check
  typedef union packed {
    blk_addr_t raw;
    blk_page_s f;
  } blk_addr_u;

  // miss input and fill report share this shape
  typedef struct packed {
    logic      valid;
    blk_addr_t addr;
  } miss_s;

  typedef struct packed {
    logic      valid;
    blk_addr_t addr;
  } pf_req_s;

endpackage

// ==== rtl/bo_defs.svh ====
// Sizing for the best-offset prefetcher.
// Addresses are block addresses with the byte offset already removed.
// BO_HISTORY and BO_MISS_DEPTH must be powers of two, since the pointers wrap.
// BO_MAX_SCORE must fit in the score type derived from it in bo_pkg.

`ifndef BO_DEFS_SVH
`define BO_DEFS_SVH

// address geometry, 4 KiB pages of 64-byte blocks
`define BO_BLK_ADDR_W    26
`define BO_PAGE_BLK_BITS 6

// candidate offsets run from 1 to 2**BO_LG_OFFSETS-1
`define BO_LG_OFFSETS    4

`define BO_HISTORY       16
`define BO_MISS_DEPTH    4

// learning phase limits
`define BO_MAX_SCORE     10
`define BO_MIN_SCORE     1
`define BO_MAX_ROUNDS    20
`define BO_INIT_OFFSET   1

`endif
